/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_quad_bram_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/quad_bram_pkg.sv */
`default_nettype none

package quad_bram_pkg;

    // Pixel payload width
    localparam int pixel_w = 16;
    // Map index width, one less than the BRAM depth log
    localparam int idx_w = 9;

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [idx_w-1:0]   map_idx_t;

    // One-hot layer sequencer states
    typedef enum logic [3:0] {
        st_idle      = 4'b0001,
        st_prime     = 4'b0010,
        st_wait_load = 4'b0100,
        st_active    = 4'b1000
    } seq_state_t;

    // Cycle counter runs 0..4
    localparam int cycle_wrap = 4;
    // Rows loaded before compute starts on a plane
    localparam int prime_rows = 2;
    // Pop to pixel output latency
    localparam int out_delay = 3;
    // Sequence read pulse latency into the cycle counter
    localparam int seq_rden_delay = 2;

endpackage

`default_nettype wire

/* logic/accel_quad_bram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_quad_bram_ctrl #(
    parameter int pfb_depth      = 64,
    parameter int num_awe        = 4,
    parameter int num_ce_per_awe = 2
) (
    input  wire logic                          clk_500MHz,
    input  wire logic                          accel_rst,
    input  quad_bram_pkg::map_idx_t            num_input_cols,
    input  quad_bram_pkg::map_idx_t            num_input_rows,
    input  quad_bram_pkg::map_idx_t            num_input_depth,
    input  wire logic                          start,
    input  wire logic                          seq_rden,
    input  wire logic                          pix_in_valid,
    input  quad_bram_pkg::pixel_t              pix_in_data,
    output logic                               pix_in_credit,
    output logic                               pixel_out_valid,
    output quad_bram_pkg::pixel_t              pixel_out_data,
    output quad_bram_pkg::seq_state_t          state,
    output quad_bram_pkg::map_idx_t            input_row,
    output quad_bram_pkg::map_idx_t            input_col,
    output logic [num_awe*num_ce_per_awe-1:0]  ce_start,
    output logic [2:0]                         cycle_counter,
    output logic [1:0]                         gray_code
);

    import quad_bram_pkg::*;

    pixel_t                          head_data;
    logic                            empty;
    logic [$clog2(pfb_depth+1)-1:0]  fill_count;
    logic                            pop;
    logic                            row_end;
    logic                            plane_end;
    logic                            map_end;
    logic                            seq_rden_dly;
    logic                            start_go;

    // Counters clear only on an accepted start
    assign start_go = start && (state == st_idle);

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    pixel_prefetch_buffer #(.pfb_depth(pfb_depth)) pfb_i (
        .clk_500MHz (clk_500MHz),
        .accel_rst  (accel_rst),
        .wr_valid   (pix_in_valid),
        .wr_data    (pix_in_data),
        .pop        (pop),
        .head_data  (head_data),
        .empty      (empty),
        .fill_count (fill_count),
        .credit     (pix_in_credit)
    );

    // Depth only feeds map_end inside the counter
    map_position_counter pos_i (
        .clk_500MHz      (clk_500MHz),
        .accel_rst       (accel_rst),
        .num_input_cols  (num_input_cols),
        .num_input_rows  (num_input_rows),
        .num_input_depth (num_input_depth),
        .start           (start_go),
        .pop             (pop),
        .col             (input_col),
        .row             (input_row),
        .depth           (),
        .row_end         (row_end),
        .plane_end       (plane_end),
        .map_end         (map_end)
    );

    layer_sequencer_fsm #(.pfb_depth(pfb_depth)) seq_i (
        .clk_500MHz     (clk_500MHz),
        .accel_rst      (accel_rst),
        .start          (start),
        .empty          (empty),
        .fill_count     (fill_count),
        .num_input_cols (num_input_cols),
        .row            (input_row),
        .row_end        (row_end),
        .plane_end      (plane_end),
        .map_end        (map_end),
        .pop            (pop),
        .state          (state)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output pipeline, data and valid aligned to the pop cycle
    delay_line #(.payload_t(pixel_t), .stages(out_delay)) data_dly_i (
        .clk_500MHz (clk_500MHz),
        .accel_rst  (accel_rst),
        .din        (head_data),
        .dout       (pixel_out_data)
    );

    delay_line #(.payload_t(logic), .stages(out_delay)) valid_dly_i (
        .clk_500MHz (clk_500MHz),
        .accel_rst  (accel_rst),
        .din        (pop),
        .dout       (pixel_out_valid)
    );

    // Sequence read pulse toward the cycle counter
    delay_line #(.payload_t(logic), .stages(seq_rden_delay)) rden_dly_i (
        .clk_500MHz (clk_500MHz),
        .accel_rst  (accel_rst),
        .din        (seq_rden),
        .dout       (seq_rden_dly)
    );

    awe_schedule #(
        .num_awe        (num_awe),
        .num_ce_per_awe (num_ce_per_awe)
    ) sched_i (
        .clk_500MHz    (clk_500MHz),
        .accel_rst     (accel_rst),
        .state         (state),
        .seq_rden_dly  (seq_rden_dly),
        .row_end       (row_end),
        .ce_start      (ce_start),
        .cycle_counter (cycle_counter),
        .gray_code     (gray_code)
    );

endmodule

`default_nettype wire

/* logic/awe_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

module awe_schedule #(
    parameter int num_awe        = 4,
    parameter int num_ce_per_awe = 2
) (
    input  wire logic                          clk_500MHz,
    input  wire logic                          accel_rst,
    input  quad_bram_pkg::seq_state_t          state,
    input  wire logic                          seq_rden_dly,
    input  wire logic                          row_end,
    output logic [num_awe*num_ce_per_awe-1:0]  ce_start,
    output logic [2:0]                         cycle_counter,
    output logic [1:0]                         gray_code
);

    import quad_bram_pkg::*;

    localparam int         ce_w     = num_awe * num_ce_per_awe;
    localparam logic [2:0] wrap_val = 3'(cycle_wrap);

    logic [1:0] row_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Staggered engine start, one engine per cycle
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            ce_start <= '0;
        end else begin
            ce_start[0] <= (state == st_active);
            for (int i = 1; i < ce_w; i++) begin
                ce_start[i] <= ce_start[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Modulo-5 cycle counter and row select
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            cycle_counter <= '0;
            row_cnt       <= '0;
        end else begin
            // Only delayed reads during compute count
            if ((state == st_active) && seq_rden_dly) begin
                cycle_counter <= (cycle_counter == wrap_val) ? '0 : cycle_counter + 1'b1;
            end
            if (row_end) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Binary row count shown as Gray
    assign gray_code = {row_cnt[1], row_cnt[1] ^ row_cnt[0]};

endmodule

`default_nettype wire

/* logic/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter type payload_t = logic,
    parameter int  stages    = 1
) (
    input  wire logic clk_500MHz,
    input  wire logic accel_rst,
    input  payload_t  din,
    output payload_t  dout
);

    // Stage 0 takes din, last stage drives dout
    payload_t pipe [stages];

    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            for (int i = 0; i < stages; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < stages; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[stages-1];

endmodule

`default_nettype wire

/* prefetch/pixel_prefetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_prefetch_buffer #(
    parameter int pfb_depth = 64
) (
    input  wire logic                          clk_500MHz,
    input  wire logic                          accel_rst,
    input  wire logic                          wr_valid,
    input  quad_bram_pkg::pixel_t              wr_data,
    input  wire logic                          pop,
    output quad_bram_pkg::pixel_t              head_data,
    output logic                               empty,
    output logic [$clog2(pfb_depth+1)-1:0]     fill_count,
    output logic                               credit
);

    import quad_bram_pkg::*;

    localparam int ptr_w = (pfb_depth > 1) ? $clog2(pfb_depth) : 1;
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(pfb_depth - 1);

    // Pixel storage, no reset needed
    pixel_t mem [pfb_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_pop;

    // Pops on an empty buffer are dropped
    assign do_pop = pop && !empty;

    always_ff @(posedge clk_500MHz) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
            credit     <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_valid, do_pop})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase
            // One credit back per popped pixel, a cycle later
            credit <= do_pop;
        end
    end

    // Show-ahead: head word is visible before the pop
    assign head_data = mem[rd_ptr];
    assign empty     = (fill_count == '0);

endmodule

`default_nettype wire

/* sequencer/layer_sequencer_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer_fsm #(
    parameter int pfb_depth = 64
) (
    input  wire logic                      clk_500MHz,
    input  wire logic                      accel_rst,
    input  wire logic                      start,
    input  wire logic                      empty,
    input  wire logic [$clog2(pfb_depth+1)-1:0] fill_count,
    input  quad_bram_pkg::map_idx_t        num_input_cols,
    input  quad_bram_pkg::map_idx_t        row,
    input  wire logic                      row_end,
    input  wire logic                      plane_end,
    input  wire logic                      map_end,
    output logic                           pop,
    output quad_bram_pkg::seq_state_t      state
);

    import quad_bram_pkg::*;

    localparam map_idx_t last_prime_row = map_idx_t'(prime_rows - 1);

    seq_state_t       ret_state;
    logic [idx_w:0]   row_len;
    // Pixels still to pop in the current row
    logic [idx_w:0]   col_left;
    logic             refilled;

    assign row_len = {1'b0, num_input_cols} + 1'b1;

    // Pop whenever a pixel is waiting in prime or active
    assign pop = ((state == st_prime) || (state == st_active)) && !empty;

    // Rest of the row is buffered; a full row at a row boundary,
    // only the short tail in the last row of the map
    assign refilled = int'(fill_count) >= int'(col_left);

    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            state     <= st_idle;
            ret_state <= st_prime;
            col_left  <= '0;
        end else begin
            if ((state == st_idle) && start) begin
                col_left <= row_len;
            end else if (pop) begin
                col_left <= row_end ? row_len : col_left - 1'b1;
            end

            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_prime;
                    end
                end
                st_prime: begin
                    if (empty) begin
                        ret_state <= st_prime;
                        state     <= st_wait_load;
                    end else if (map_end) begin
                        state <= st_idle;
                    end else if (row_end && !plane_end && row == last_prime_row) begin
                        // Second row of the plane is in
                        state <= st_active;
                    end
                end
                st_active: begin
                    if (empty) begin
                        ret_state <= st_active;
                        state     <= st_wait_load;
                    end else if (map_end) begin
                        state <= st_idle;
                    end else if (plane_end) begin
                        // Next plane primes again
                        state <= st_prime;
                    end
                end
                st_wait_load: begin
                    if (refilled) begin
                        state <= ret_state;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sequencer/map_position_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module map_position_counter (
    input  wire logic              clk_500MHz,
    input  wire logic              accel_rst,
    input  quad_bram_pkg::map_idx_t num_input_cols,
    input  quad_bram_pkg::map_idx_t num_input_rows,
    input  quad_bram_pkg::map_idx_t num_input_depth,
    input  wire logic              start,
    input  wire logic              pop,
    output quad_bram_pkg::map_idx_t col,
    output quad_bram_pkg::map_idx_t row,
    output quad_bram_pkg::map_idx_t depth,
    output logic                   row_end,
    output logic                   plane_end,
    output logic                   map_end
);

    // Flags describe the pixel being popped right now
    assign row_end   = pop && (col == num_input_cols);
    assign plane_end = row_end && (row == num_input_rows);
    assign map_end   = plane_end && (depth == num_input_depth);

    // Index of the next pixel, wraps column then row then depth
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst || start) begin
            col   <= '0;
            row   <= '0;
            depth <= '0;
        end else if (pop) begin
            if (!row_end) begin
                col <= col + 1'b1;
            end else begin
                col <= '0;
                if (!plane_end) begin
                    row <= row + 1'b1;
                end else begin
                    row <= '0;
                    // Depth back to 0 after the last plane
                    depth <= map_end ? '0 : depth + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_quad_bram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_quad_bram_ctrl;

    import quad_bram_pkg::*;

    // Match the DUT defaults
    localparam int pfb_depth      = 64;
    localparam int num_awe        = 4;
    localparam int num_ce_per_awe = 2;
    localparam int ce_w           = num_awe * num_ce_per_awe;
    // Cycle counter runs 0..4
    localparam int cycle_last     = 4;

    logic            clk_500MHz;
    logic            accel_rst;
    map_idx_t        num_input_cols;
    map_idx_t        num_input_rows;
    map_idx_t        num_input_depth;
    logic            start;
    logic            seq_rden;
    logic            pix_in_valid;
    pixel_t          pix_in_data;
    logic            pix_in_credit;
    logic            pixel_out_valid;
    pixel_t          pixel_out_data;
    seq_state_t      state;
    map_idx_t        input_row;
    map_idx_t        input_col;
    logic [ce_w-1:0] ce_start;
    logic [2:0]      cycle_counter;
    logic [1:0]      gray_code;

    // Source side
    pixel_t      sent_q[$];
    int          credits;
    int          credits_back;
    int          sent_total;
    int          send_target;
    logic [31:0] rng_state;

    // Monitor side
    int          out_count    = 0;
    int          gray_changes = 0;
    seq_state_t  mon_state;
    seq_state_t  prev_state;
    logic        prev_start;
    logic [1:0]  prev_gray;
    logic [2:0]  rden_hist;
    int          exp_cycle;
    int          active_run;
    int          quiet_run;
    pixel_t      exp_pix;
    int          pos_index;
    int          map_w;
    int          map_h;
    logic [1:0]  credit_hist;

    initial clk_500MHz = 1'b0;
    always #2 clk_500MHz = ~clk_500MHz;

    accel_quad_bram_ctrl dut_i (
        .clk_500MHz      (clk_500MHz),
        .accel_rst       (accel_rst),
        .num_input_cols  (num_input_cols),
        .num_input_rows  (num_input_rows),
        .num_input_depth (num_input_depth),
        .start           (start),
        .seq_rden        (seq_rden),
        .pix_in_valid    (pix_in_valid),
        .pix_in_data     (pix_in_data),
        .pix_in_credit   (pix_in_credit),
        .pixel_out_valid (pixel_out_valid),
        .pixel_out_data  (pixel_out_data),
        .state           (state),
        .input_row       (input_row),
        .input_col       (input_col),
        .ce_start        (ce_start),
        .cycle_counter   (cycle_counter),
        .gray_code       (gray_code)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Pixels in a map of the given size
    function automatic int expected_pixel_count(input int width, input int height,
                                                input int planes);
        return width * height * planes;
    endfunction

    // 40 cycles per pixel over all maps plus slack
    function automatic int watchdog_cycles();
        int total;
        total = expected_pixel_count(4, 3, 2) + expected_pixel_count(8, 2, 1)
              + expected_pixel_count(8, 4, 1);
        return 40 * total + 400;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "Run stopped");
    endtask

    // Optional preload then start pulse and per-map totals
    task automatic run_map(input string name, input int width, input int height,
                           input int planes, input bit preload);
        int expected;
        int out_base;
        int gray_base;
        int back_base;
        expected = expected_pixel_count(width, height, planes);
        @(posedge clk_500MHz);
        out_base    = out_count;
        gray_base   = gray_changes;
        back_base   = credits_back;
        send_target = send_target + expected;
        if (preload) begin
            while (sent_total < send_target) begin
                @(posedge clk_500MHz);
            end
        end
        #1;
        num_input_cols  = map_idx_t'(width - 1);
        num_input_rows  = map_idx_t'(height - 1);
        num_input_depth = map_idx_t'(planes - 1);
        start           = 1'b1;
        @(posedge clk_500MHz);
        #1;
        start = 1'b0;
        while (out_count - out_base < expected) begin
            @(posedge clk_500MHz);
        end
        compare_values({name, " idle after last pixel"}, 32'(st_idle), 32'(mon_state));
        // Let the start chain and credit pulses drain
        repeat (ce_w + 4) @(posedge clk_500MHz);
        compare_values({name, " row steps"}, 32'(height * planes),
                       32'(gray_changes - gray_base));
        compare_values({name, " credits returned"}, 32'(expected),
                       32'(credits_back - back_base));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Credit-respecting pixel source with random gaps and seq_rden
    initial begin
        pix_in_valid = 1'b0;
        pix_in_data  = '0;
        seq_rden     = 1'b0;
        credits      = pfb_depth;
        credits_back = 0;
        sent_total   = 0;
        rng_state    = 32'h3f8;
        forever begin
            @(posedge clk_500MHz);
            #1;
            if (pix_in_credit) begin
                credits      = credits + 1;
                credits_back = credits_back + 1;
            end
            rng_state = xorshift32(rng_state);
            seq_rden  = rng_state[7];
            if ((credits > 0) && (sent_total < send_target) && rng_state[3]) begin
                pix_in_valid = 1'b1;
                pix_in_data  = rng_state[31:16];
                sent_q.push_back(rng_state[31:16]);
                credits    = credits - 1;
                sent_total = sent_total + 1;
            end else begin
                pix_in_valid = 1'b0;
            end
            compare_values("source credits in range", 32'd1,
                           32'((credits >= 0) && (credits <= pfb_depth)));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor sampled mid-cycle
    always @(negedge clk_500MHz) begin
        if (accel_rst) begin
            prev_state  = state;
            prev_start  = start;
            prev_gray   = gray_code;
            mon_state   = state;
            rden_hist   = '0;
            exp_cycle   = 0;
            active_run  = 0;
            quiet_run   = 0;
            pos_index   = 0;
            credit_hist = '0;
        end else begin
            if (pixel_out_valid) begin
                if (sent_q.size() == 0) begin
                    stop_on_failure("An output pixel appeared that the source never sent");
                end else begin
                    exp_pix = sent_q.pop_front();
                    compare_values("pixel order", 32'(exp_pix), 32'(pixel_out_data));
                    out_count = out_count + 1;
                end
            end
            // Valid output trails the credit pulse by two cycles
            compare_values("output latency", 32'(credit_hist[1]), 32'(pixel_out_valid));
            // Next pixel position from the count of returned credits
            map_w = int'(num_input_cols) + 1;
            map_h = int'(num_input_rows) + 1;
            if (pix_in_credit) begin
                pos_index = (pos_index + 1)
                          % expected_pixel_count(map_w, map_h, int'(num_input_depth) + 1);
            end
            compare_values("input column", 32'(pos_index % map_w), 32'(input_col));
            compare_values("input row", 32'((pos_index / map_w) % map_h), 32'(input_row));
            compare_values("buffer fill bound", 32'd1,
                           32'(dut_i.fill_count <= pfb_depth));
            if ((prev_state == st_idle) && (state != st_idle)) begin
                compare_values("idle left only on start", 32'd1, 32'(prev_start));
            end
            if (gray_code != prev_gray) begin
                compare_values("gray single bit step", 32'd1,
                               32'($countones(gray_code ^ prev_gray)));
                gray_changes = gray_changes + 1;
            end
            // Read pulse from three samples back lands if last cycle was active
            if ((prev_state == st_active) && rden_hist[2]) begin
                exp_cycle = (exp_cycle == cycle_last) ? 0 : exp_cycle + 1;
            end
            compare_values("cycle counter", 32'(exp_cycle), 32'(cycle_counter));
            // Bit i mirrors the state i+1 samples back
            if (active_run >= ce_w) begin
                compare_values("ce_start all high", 32'((1 << ce_w) - 1), 32'(ce_start));
            end
            if ((state == st_idle) && (quiet_run >= ce_w)) begin
                compare_values("ce_start drained", 32'd0, 32'(ce_start));
            end
            rden_hist   = {rden_hist[1:0], seq_rden};
            credit_hist = {credit_hist[0], pix_in_credit};
            active_run  = (state == st_active) ? active_run + 1 : 0;
            quiet_run   = (state != st_active) ? quiet_run + 1 : 0;
            prev_state  = state;
            prev_start  = start;
            prev_gray   = gray_code;
            mon_state   = state;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        accel_rst       = 1'b1;
        start           = 1'b0;
        num_input_cols  = '0;
        num_input_rows  = '0;
        num_input_depth = '0;
        send_target     = 0;
        repeat (2) @(posedge clk_500MHz);
        #1;
        accel_rst = 1'b0;
        run_map("map 4x3x2", 4, 3, 2, 1'b0);
        // Second start on a fresh map
        run_map("map 8x2x1", 8, 2, 1, 1'b0);
        // Whole map buffered first for a long active run
        run_map("map 8x4x1 preloaded", 8, 4, 1, 1'b1);
        $display(">>> PASS");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles()) @(posedge clk_500MHz);
        $display("Timeout: the maps did not finish in the expected number of cycles");
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* verilog.f */
common/quad_bram_pkg.sv
logic/delay_line.sv
prefetch/pixel_prefetch_buffer.sv
sequencer/map_position_counter.sv
sequencer/layer_sequencer_fsm.sv
logic/awe_schedule.sv
logic/accel_quad_bram_ctrl.sv
testbench/tb_quad_bram_ctrl.sv
